/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // reset vector and canonical nop (andi r0, r0, 0)
    localparam logic [31:0] PC_RESET = 32'h1c00_0000;
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // fetch queue geometry
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    // one IF1 fetch packet, two instructions wide
    typedef struct packed {
        logic        spare;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic [6:0]  excp_code;
        logic [1:0]  excp_flag;
        logic [31:0] cookie;
    } fetch_pkt_t;

endpackage

`default_nettype wire

/* serial_pkg.sv */
`default_nettype none

package serial_pkg;

    // serializing FSM states
    typedef enum logic [2:0] {
        IDLE            = 3'b000,
        WAIT_EX_IBAR    = 3'b001,
        WAIT_EX_CSR     = 3'b010,
        WAIT_CACHE_IDLE = 3'b011,
        WAIT_CSR_OK     = 3'b100,
        WAIT_TLB_OK     = 3'b101,
        WAIT_EX_TLB     = 3'b111
    } ser_state_t;

    // kind of serializing instruction picked from the hints
    typedef enum logic [1:0] {
        SER_NONE = 2'b00,
        SER_IBAR = 2'b01,
        SER_CSR  = 2'b10,
        SER_TLB  = 2'b11
    } ser_kind_t;

    // pre-decode slot mask, bit 0 is slot 0
    typedef logic [1:0] ser_hint_t;

    localparam int HINT_SLOT0 = 0;

    // restart offset past the serializing instruction
    localparam logic [31:0] REDIRECT_OFS_SLOT0 = 32'd4;
    localparam logic [31:0] REDIRECT_OFS_SLOT1 = 32'd8;

endpackage

`default_nettype wire

/* fetch_pkt_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_pkt_if;
    import fetch_pkg::*;

    logic       valid;
    logic       ready;
    fetch_pkt_t pkt;

    // producer side, the IF1 stage register
    modport source (
        output valid,
        output pkt,
        input  ready
    );

    // consumer side, the fetch queue
    modport sink (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

`default_nettype wire

/* serialize_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module serialize_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  serial_pkg::ser_hint_t ibar_hint,
    input  serial_pkg::ser_hint_t csr_hint,
    input  serial_pkg::ser_hint_t tlb_hint,
    input  logic                  accept,
    input  logic [31:0]           accept_pc,
    input  logic                  ibar_from_ex,
    input  logic                  csr_from_ex,
    input  logic                  tlb_from_ex,
    input  logic                  icache_idle,
    input  logic                  dcache_idle,
    input  logic                  csr_done,
    input  logic                  tlb_done,
    output logic                  ser_busy,
    output logic                  fetch_flush,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc
);
    import fetch_pkg::*;
    import serial_pkg::*;

    ser_state_t state;
    ser_state_t state_nxt;
    ser_kind_t  kind;
    ser_hint_t  sel_hint;
    logic       cache_idle;

    assign cache_idle = icache_idle && dcache_idle;

    // ibar beats csr, csr beats tlb
    always_comb begin
        kind     = SER_NONE;
        sel_hint = '0;
        if (|ibar_hint) begin
            kind     = SER_IBAR;
            sel_hint = ibar_hint;
        end else if (|csr_hint) begin
            kind     = SER_CSR;
            sel_hint = csr_hint;
        end else if (|tlb_hint) begin
            kind     = SER_TLB;
            sel_hint = tlb_hint;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // hints only count on the packet being taken
                if (accept) begin
                    case (kind)
                        SER_IBAR: state_nxt = WAIT_EX_IBAR;
                        SER_CSR:  state_nxt = WAIT_EX_CSR;
                        SER_TLB:  state_nxt = WAIT_EX_TLB;
                        default:  state_nxt = IDLE;
                    endcase
                end
            end
            WAIT_EX_IBAR:    if (ibar_from_ex) state_nxt = WAIT_CACHE_IDLE;
            WAIT_EX_CSR:     if (csr_from_ex) state_nxt = WAIT_CSR_OK;
            WAIT_EX_TLB:     if (tlb_from_ex) state_nxt = WAIT_TLB_OK;
            WAIT_CACHE_IDLE: if (cache_idle) state_nxt = IDLE;
            WAIT_CSR_OK:     if (csr_done) state_nxt = IDLE;
            WAIT_TLB_OK:     if (tlb_done) state_nxt = IDLE;
            default:         state_nxt = IDLE;
        endcase
        if (flush) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= IDLE;
            redirect_pc <= PC_RESET;
        end else begin
            state <= state_nxt;
            // latch restart point on entry to a wait state
            if (state == IDLE && state_nxt != IDLE) begin
                redirect_pc <= accept_pc + (sel_hint[HINT_SLOT0] ? REDIRECT_OFS_SLOT0
                                                                 : REDIRECT_OFS_SLOT1);
            end
        end
    end

    // busy from the edge after a serializing packet is taken
    assign ser_busy       = (state != IDLE);
    assign fetch_flush    = (state == WAIT_EX_IBAR) || (state == WAIT_EX_CSR) ||
                            (state == WAIT_EX_TLB);
    assign redirect_valid = (state != IDLE);

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(state) && (state inside {IDLE, WAIT_EX_IBAR, WAIT_EX_CSR, WAIT_EX_TLB,
                                             WAIT_CACHE_IDLE, WAIT_CSR_OK, WAIT_TLB_OK}));

endmodule

`default_nettype wire

/* skid_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fetch_pkg::fetch_pkt_t in_pkt,
    input  logic                 ser_busy,
    input  logic                 slot0_ser,
    fetch_pkt_if.source          out
);
    import fetch_pkg::*;

    logic       main_valid;
    fetch_pkt_t main_pkt;
    logic       skid_valid;
    fetch_pkt_t skid_pkt;
    fetch_pkt_t sq_pkt;
    logic       accept;
    logic       xfer;
    logic       main_free;

    // slot 1 is younger than a serializing op in slot 0, so kill it
    always_comb begin
        sq_pkt = in_pkt;
        if (slot0_ser) begin
            sq_pkt.inst1     = INST_NOP;
            sq_pkt.excp_flag = '0;
        end
    end

    assign in_ready  = !skid_valid && !ser_busy;
    assign accept    = in_valid && in_ready;
    assign xfer      = main_valid && out.ready;
    assign main_free = !main_valid || xfer;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // skid entry is older, it goes first
            if (skid_valid) begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                main_valid <= accept;
            end
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                main_pkt <= skid_pkt;
            end else if (accept) begin
                main_pkt <= sq_pkt;
            end
        end else if (accept) begin
            skid_pkt <= sq_pkt;
        end
    end

    assign out.valid = main_valid;
    assign out.pkt   = main_pkt;

    // held packet must wait for the queue to take it
    a_valid_held: assert property (@(posedge clk) disable iff (!rstn)
        out.valid && !out.ready && !flush |=> out.valid);

    a_pkt_stable: assert property (@(posedge clk) disable iff (!rstn)
        out.valid && !out.ready && !flush |=> $stable(out.pkt));

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    fetch_pkt_if.sink             in,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_pkt_t out_pkt
);
    import fetch_pkg::*;

    fetch_pkt_t             mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   full;
    logic                   push;
    logic                   pop;

    assign full      = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign in.ready  = !full;
    assign out_valid = (count != '0);
    assign out_pkt   = mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.pkt;
        end
    end

    // a write when full or a read when empty would wrap the count
    a_count_range: assert property (@(posedge clk) disable iff (!rstn)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH));

    // read pointer trails write pointer by the occupancy
    a_ptr_gap: assert property (@(posedge clk) disable iff (!rstn)
        ((int'(rd_ptr) + int'(count)) % QUEUE_DEPTH) == int'(wr_ptr));

endmodule

`default_nettype wire

/* if1_fifo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module if1_fifo_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic                  if1_valid,
    output logic                  if1_ready,
    input  logic [31:0]           if1_pc,
    input  logic [31:0]           if1_pc_next,
    input  logic [31:0]           if1_inst0,
    input  logic [31:0]           if1_inst1,
    input  logic [31:0]           if1_badv,
    input  logic [6:0]            if1_excp_code,
    input  logic [1:0]            if1_excp_flag,
    input  logic [31:0]           if1_cookie,
    input  serial_pkg::ser_hint_t ibar_hint,
    input  serial_pkg::ser_hint_t csr_hint,
    input  serial_pkg::ser_hint_t tlb_hint,
    input  logic                  ibar_from_ex,
    input  logic                  csr_from_ex,
    input  logic                  tlb_from_ex,
    input  logic                  icache_idle,
    input  logic                  dcache_idle,
    input  logic                  csr_done,
    input  logic                  tlb_done,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [31:0]           out_pc,
    output logic [31:0]           out_pc_next,
    output logic [31:0]           out_inst0,
    output logic [31:0]           out_inst1,
    output logic [31:0]           out_badv,
    output logic [6:0]            out_excp_code,
    output logic [1:0]            out_excp_flag,
    output logic [31:0]           out_cookie,
    output logic                  fetch_flush,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc
);
    import fetch_pkg::*;
    import serial_pkg::*;

    fetch_pkt_t in_pkt;
    fetch_pkt_t q_pkt;
    logic       ser_busy;
    logic       slot0_ser;
    logic       accept;

    fetch_pkt_if pkt_if ();

    assign in_pkt = '{spare: 1'b0, pc: if1_pc, pc_next: if1_pc_next, inst0: if1_inst0,
                      inst1: if1_inst1, badv: if1_badv, excp_code: if1_excp_code,
                      excp_flag: if1_excp_flag, cookie: if1_cookie};

    // any serializing kind sitting in slot 0
    assign slot0_ser = ibar_hint[HINT_SLOT0] || csr_hint[HINT_SLOT0] || tlb_hint[HINT_SLOT0];
    assign accept    = if1_valid && if1_ready;

    serialize_fsm u_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .ibar_hint      (ibar_hint),
        .csr_hint       (csr_hint),
        .tlb_hint       (tlb_hint),
        .accept         (accept),
        .accept_pc      (if1_pc),
        .ibar_from_ex   (ibar_from_ex),
        .csr_from_ex    (csr_from_ex),
        .tlb_from_ex    (tlb_from_ex),
        .icache_idle    (icache_idle),
        .dcache_idle    (dcache_idle),
        .csr_done       (csr_done),
        .tlb_done       (tlb_done),
        .ser_busy       (ser_busy),
        .fetch_flush    (fetch_flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    skid_stage u_skid (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in_valid  (if1_valid),
        .in_ready  (if1_ready),
        .in_pkt    (in_pkt),
        .ser_busy  (ser_busy),
        .slot0_ser (slot0_ser),
        .out       (pkt_if.source)
    );

    fetch_queue u_queue (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in        (pkt_if.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (q_pkt)
    );

    assign out_pc        = q_pkt.pc;
    assign out_pc_next   = q_pkt.pc_next;
    assign out_inst0     = q_pkt.inst0;
    assign out_inst1     = q_pkt.inst1;
    assign out_badv      = q_pkt.badv;
    assign out_excp_code = q_pkt.excp_code;
    assign out_excp_flag = q_pkt.excp_flag;
    assign out_cookie    = q_pkt.cookie;

endmodule

`default_nettype wire

/* tb_if1_fifo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_if1_fifo_top;
    import fetch_pkg::*;
    import serial_pkg::*;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        if1_valid;
    logic        if1_ready;
    logic [31:0] if1_pc, if1_pc_next, if1_inst0, if1_inst1, if1_badv, if1_cookie;
    logic [6:0]  if1_excp_code;
    logic [1:0]  if1_excp_flag;
    ser_hint_t   ibar_hint, csr_hint, tlb_hint;
    logic        ibar_from_ex, csr_from_ex, tlb_from_ex;
    logic        icache_idle, dcache_idle, csr_done, tlb_done;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_pc, out_pc_next, out_inst0, out_inst1, out_badv, out_cookie;
    logic [6:0]  out_excp_code;
    logic [1:0]  out_excp_flag;
    logic        fetch_flush;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    int         seed = 15136;
    string      test_name;
    // packets the decoder side should see, oldest first
    fetch_pkt_t expect_q [$];

    if1_fifo_top uut (.*);

    always #4 clk = ~clk;

    task fail(input string what);
        $display("ERROR in %s: %s", test_name, what);
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task check(input string item, input logic [199:0] exp, input logic [199:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, item, exp, act);
            $display("Simulation failed");
            $fatal(1, "run stopped on mismatch");
        end
    endtask

    task make_pkt(output fetch_pkt_t p);
        p           = '0;
        p.pc        = $random(seed) & 32'hffff_fffc;
        p.pc_next   = p.pc + 32'd8;
        p.inst0     = $random(seed);
        p.inst1     = $random(seed);
        p.badv      = $random(seed);
        p.excp_code = $random(seed);
        p.excp_flag = $random(seed);
        p.cookie    = $random(seed);
    endtask

    task drive_fields(input fetch_pkt_t p);
        if1_pc        = p.pc;
        if1_pc_next   = p.pc_next;
        if1_inst0     = p.inst0;
        if1_inst1     = p.inst1;
        if1_badv      = p.badv;
        if1_excp_code = p.excp_code;
        if1_excp_flag = p.excp_flag;
        if1_cookie    = p.cookie;
    endtask

    // present one packet, give up after limit cycles without if1_ready
    task offer(input fetch_pkt_t p, input ser_hint_t ih, ch, th, input int limit,
               output bit took);
        fetch_pkt_t exp;
        int         n;
        exp = p;
        if (ih[0] || ch[0] || th[0]) begin
            // slot 1 is younger than a serializing slot 0
            exp.inst1     = INST_NOP;
            exp.excp_flag = 2'b00;
        end
        took = 1'b0;
        n    = 0;
        @(negedge clk);
        drive_fields(p);
        if1_valid = 1'b1;
        ibar_hint = ih;
        csr_hint  = ch;
        tlb_hint  = th;
        #1;
        while (!if1_ready && n < limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (if1_ready) begin
            @(posedge clk);
            expect_q.push_back(exp);
            took = 1'b1;
        end
        @(negedge clk);
        if1_valid = 1'b0;
        ibar_hint = '0;
        csr_hint  = '0;
        tlb_hint  = '0;
    endtask

    task send(input fetch_pkt_t p, input ser_hint_t ih, ch, th);
        bit took;
        offer(p, ih, ch, th, 40, took);
        if (!took) begin
            fail("if1_ready never came up for a packet");
        end
    endtask

    task wait_drain;
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (expect_q.size() != 0) begin
            fail("sent packets were not delivered in time");
        end
    endtask

    task wait_ready;
        int n;
        n = 0;
        #1;
        while (!if1_ready && n < 50) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!if1_ready) begin
            fail("if1_ready stayed low after the completion input");
        end
    endtask

    // kind 0 ibar, 1 csr, 2 tlb; done picks the completion input over the ex confirm
    task drive_ctl(input int kind, input bit done, input logic v);
        case (kind)
            0: if (done) {icache_idle, dcache_idle} = {v, v}; else ibar_from_ex = v;
            1: if (done) csr_done = v; else csr_from_ex = v;
            default: if (done) tlb_done = v; else tlb_from_ex = v;
        endcase
    endtask

    task pulse(input int kind, input bit done);
        @(negedge clk);
        drive_ctl(kind, done, 1'b1);
        @(negedge clk);
        drive_ctl(kind, done, 1'b0);
        #1;
    endtask

    task serial_case(input string name, input int kind, input ser_hint_t hint);
        fetch_pkt_t  p;
        logic [31:0] ofs;
        test_name = name;
        @(negedge clk);
        out_ready = 1'b1;
        make_pkt(p);
        p.excp_flag = 2'b11;
        ofs = hint[0] ? 32'd4 : 32'd8;
        send(p, (kind == 0) ? hint : 2'b00, (kind == 1) ? hint : 2'b00,
             (kind == 2) ? hint : 2'b00);
        #1;
        check("fetch_flush", 1, fetch_flush);
        check("redirect_valid", 1, redirect_valid);
        check("redirect_pc", p.pc + ofs, redirect_pc);
        check("if1_ready while busy", 0, if1_ready);
        wait_drain;
        // completion ahead of the ex confirm is ignored
        pulse(kind, 1'b1);
        check("if1_ready after early done", 0, if1_ready);
        pulse(kind, 1'b0);
        check("if1_ready after ex confirm", 0, if1_ready);
        check("redirect_pc held", p.pc + ofs, redirect_pc);
        pulse(kind, 1'b1);
        wait_ready;
    endtask

    task test_passthrough;
        fetch_pkt_t p;
        test_name = "passthrough";
        @(negedge clk);
        out_ready = 1'b1;
        repeat (8) begin
            make_pkt(p);
            send(p, 2'b00, 2'b00, 2'b00);
        end
        wait_drain;
    endtask

    task test_backpressure;
        fetch_pkt_t p;
        bit         took;
        int         n;
        test_name = "backpressure";
        @(negedge clk);
        out_ready = 1'b0;
        n    = 0;
        took = 1'b1;
        while (took && n < 20) begin
            make_pkt(p);
            offer(p, 2'b00, 2'b00, 2'b00, 4, took);
            if (took) begin
                n++;
            end
        end
        // queue entries plus stage register plus skid slot
        check("accepted before stall", QUEUE_DEPTH + 2, n);
        @(negedge clk);
        out_ready = 1'b1;
        wait_drain;
    endtask

    task test_flush;
        fetch_pkt_t p;
        test_name = "flush";
        @(negedge clk);
        out_ready = 1'b0;
        repeat (2) begin
            make_pkt(p);
            send(p, 2'b00, 2'b00, 2'b00);
        end
        make_pkt(p);
        send(p, 2'b00, 2'b10, 2'b00);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        out_ready = 1'b1;
        expect_q.delete();
        #1;
        check("out_valid after flush", 0, out_valid);
        check("redirect_valid after flush", 0, redirect_valid);
        check("if1_ready after flush", 1, if1_ready);
        make_pkt(p);
        send(p, 2'b00, 2'b00, 2'b00);
        wait_drain;
    endtask

    // decoder side, a transfer is due on the coming rising edge
    always begin : deliver_mon
        fetch_pkt_t act;
        fetch_pkt_t exp;
        @(negedge clk);
        #2;
        if (rstn && !flush && out_valid && out_ready) begin
            act = '{spare: 1'b0, pc: out_pc, pc_next: out_pc_next, inst0: out_inst0,
                    inst1: out_inst1, badv: out_badv, excp_code: out_excp_code,
                    excp_flag: out_excp_flag, cookie: out_cookie};
            if (expect_q.size() == 0) begin
                fail("a packet came out that was never sent");
            end else begin
                exp = expect_q.pop_front();
                check("out packet", exp, act);
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        flush        = 1'b0;
        if1_valid    = 1'b0;
        drive_fields('0);
        ibar_hint    = '0;
        csr_hint     = '0;
        tlb_hint     = '0;
        ibar_from_ex = 1'b0;
        csr_from_ex  = 1'b0;
        tlb_from_ex  = 1'b0;
        icache_idle  = 1'b0;
        dcache_idle  = 1'b0;
        csr_done     = 1'b0;
        tlb_done     = 1'b0;
        out_ready    = 1'b0;
        test_name    = "reset";
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        #1;
        check("out_valid", 0, out_valid);
        check("fetch_flush", 0, fetch_flush);
        check("redirect_valid", 0, redirect_valid);
        test_passthrough;
        test_backpressure;
        serial_case("ibar_slot0", 0, 2'b01);
        serial_case("csr_slot1", 1, 2'b10);
        serial_case("tlb_slot0", 2, 2'b01);
        test_flush;
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
fetch_pkg.sv
serial_pkg.sv
fetch_pkt_if.sv
serialize_fsm.sv
skid_stage.sv
fetch_queue.sv
if1_fifo_top.sv
tb_if1_fifo_top.sv
